/* source/can_frame_pkg.sv */
// CAN frame field types, frame layout, CRC polynomial and CRC feed bit order
`default_nettype none

package can_frame_pkg;

  localparam int CAN_ID_W    = 11;
  localparam int CAN_DLC_W   = 4;
  localparam int CAN_DATA_W  = 64;
  localparam int CAN_CRC_W   = 15;
  localparam int CAN_FRAME_W = 128;

  // Header bits fed to the CRC, sof through dlc
  localparam int CAN_HDR_BITS = 19;

  localparam logic [CAN_CRC_W-1:0] CAN_CRC_POLY = 15'h4599;

  typedef logic [CAN_ID_W-1:0]   can_id_t;
  typedef logic [CAN_DLC_W-1:0]  can_dlc_t;
  // Byte 0 sits in the top byte
  typedef logic [CAN_DATA_W-1:0] can_data_t;
  typedef logic [CAN_CRC_W-1:0]  can_crc_t;

  typedef struct packed {
    logic [29:0] pad;
    can_crc_t    crc;
    can_data_t   data;
    can_dlc_t    dlc;
    logic        r0;
    logic        ide;
    logic        rtr;
    can_id_t     id;
    logic        sof;
  } can_fields_t;

  typedef union packed {
    can_fields_t            fields;
    logic [CAN_FRAME_W-1:0] raw;
  } can_frame_u;

  // Feed step k to raw bit position, in wire order
  function automatic logic [6:0] can_bit_index(input logic [6:0] k);
    logic [6:0] idx;
    if (k == 7'd0) begin
      idx = 7'd0;
    end else if (k <= 7'd11) begin
      // id msb first
      idx = 7'd12 - k;
    end else if (k <= 7'd14) begin
      // rtr, ide, r0
      idx = k;
    end else if (k < 7'(CAN_HDR_BITS)) begin
      idx = 7'd33 - k;
    end else begin
      // data from bit 82 down
      idx = 7'd101 - k;
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

/* source/can_regmap_pkg.sv */
// Register word offsets, control and status bit positions, AXI response codes
`default_nettype none

package can_regmap_pkg;

  // Word offsets, address bits 5:2
  localparam logic [3:0] REG_ID      = 4'd0;
  localparam logic [3:0] REG_DATA0   = 4'd1;
  localparam logic [3:0] REG_DATA1   = 4'd2;
  localparam logic [3:0] REG_DATA2   = 4'd3;
  localparam logic [3:0] REG_DATA3   = 4'd4;
  localparam logic [3:0] REG_DATA4   = 4'd5;
  localparam logic [3:0] REG_DATA5   = 4'd6;
  localparam logic [3:0] REG_DATA6   = 4'd7;
  localparam logic [3:0] REG_DATA7   = 4'd8;
  localparam logic [3:0] REG_CONTROL = 4'd9;
  localparam logic [3:0] REG_STATUS  = 4'd10;

  // Control word, dlc occupies bits 3:0
  localparam int CTRL_DLC      = 0;
  localparam int CTRL_RTR      = 4;
  localparam int CTRL_IDE      = 5;
  localparam int CTRL_ASSEMBLE = 6;

  localparam int STAT_READY = 0;
  localparam int STAT_BUSY  = 1;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

/* source/can_axil_regs.sv */
// AXI4-Lite slave holding the CAN frame field registers and issuing the assemble start
`timescale 1ns/1ns
`default_nettype none

module can_axil_regs #(
  parameter int AXI_ADDR_WIDTH = 32
) (
  input  wire                      s_axi_aclk,
  input  wire                      s_axi_aresetn,
  input  wire [AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
  input  wire [2:0]                s_axi_awprot,
  input  wire                      s_axi_awvalid,
  output logic                     s_axi_awready,
  input  wire [31:0]               s_axi_wdata,
  input  wire [3:0]                s_axi_wstrb,
  input  wire                      s_axi_wvalid,
  output logic                     s_axi_wready,
  output logic [1:0]               s_axi_bresp,
  output logic                     s_axi_bvalid,
  input  wire                      s_axi_bready,
  input  wire [AXI_ADDR_WIDTH-1:0] s_axi_araddr,
  input  wire [2:0]                s_axi_arprot,
  input  wire                      s_axi_arvalid,
  output logic                     s_axi_arready,
  output logic [31:0]              s_axi_rdata,
  output logic [1:0]               s_axi_rresp,
  output logic                     s_axi_rvalid,
  input  wire                      s_axi_rready,
  input  wire                      ready,
  input  wire                      busy,
  output can_frame_pkg::can_id_t   id,
  output can_frame_pkg::can_dlc_t  dlc,
  output logic                     rtr,
  output logic                     ide,
  output can_frame_pkg::can_data_t data,
  output logic                     start
);

  import can_frame_pkg::*;
  import can_regmap_pkg::*;

  logic             aw_hs;
  logic             w_hs;
  logic             ar_hs;
  logic [3:0]       waddr_q;
  logic [31:0]      wdata_q;
  logic             wr_en;
  logic [0:7][7:0]  data_q;
  logic [2:0]       wbyte;
  logic [3:0]       raddr;
  logic [2:0]       rbyte;
  logic [31:0]      rdata_mux;

  assign aw_hs = s_axi_awvalid & s_axi_awready;
  assign w_hs  = s_axi_wvalid & s_axi_wready;
  assign ar_hs = s_axi_arvalid & s_axi_arready;

  // Every access completes OKAY
  assign s_axi_bresp = AXI_RESP_OKAY;
  assign s_axi_rresp = AXI_RESP_OKAY;

  assign wbyte = 3'(waddr_q - REG_DATA0);
  assign raddr = s_axi_araddr[5:2];
  assign rbyte = 3'(raddr - REG_DATA0);
  assign data  = data_q;

  // Write address, data and response channels
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      s_axi_bvalid  <= 1'b0;
      wr_en         <= 1'b0;
    end else begin
      s_axi_awready <= ~s_axi_awready & s_axi_awvalid;
      if (aw_hs) begin
        s_axi_wready <= 1'b1;
      end else if (w_hs) begin
        s_axi_wready <= 1'b0;
      end
      // Only byte lane 0 enables the write
      wr_en <= w_hs & s_axi_wstrb[0];
      if (w_hs) begin
        s_axi_bvalid <= 1'b1;
      end else if (s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (aw_hs) begin
      waddr_q <= s_axi_awaddr[5:2];
    end
    if (w_hs) begin
      wdata_q <= s_axi_wdata;
    end
  end

  // Field registers, assemble bit becomes the start pulse
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      id     <= '0;
      dlc    <= '0;
      rtr    <= 1'b0;
      ide    <= 1'b0;
      data_q <= '0;
      start  <= 1'b0;
    end else begin
      start <= 1'b0;
      if (wr_en) begin
        case (waddr_q)
          REG_ID: id <= wdata_q[CAN_ID_W-1:0];
          REG_DATA0, REG_DATA1, REG_DATA2, REG_DATA3,
          REG_DATA4, REG_DATA5, REG_DATA6, REG_DATA7: data_q[wbyte] <= wdata_q[7:0];
          REG_CONTROL: begin
            dlc   <= wdata_q[CTRL_DLC +: CAN_DLC_W];
            rtr   <= wdata_q[CTRL_RTR];
            ide   <= wdata_q[CTRL_IDE];
            start <= wdata_q[CTRL_ASSEMBLE];
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Read mux, assemble bit always reads back as zero
  always_comb begin
    rdata_mux = '0;
    case (raddr)
      REG_ID: rdata_mux[CAN_ID_W-1:0] = id;
      REG_DATA0, REG_DATA1, REG_DATA2, REG_DATA3,
      REG_DATA4, REG_DATA5, REG_DATA6, REG_DATA7: rdata_mux[7:0] = data_q[rbyte];
      REG_CONTROL: begin
        rdata_mux[CTRL_DLC +: CAN_DLC_W] = dlc;
        rdata_mux[CTRL_RTR]              = rtr;
        rdata_mux[CTRL_IDE]              = ide;
      end
      REG_STATUS: begin
        rdata_mux[STAT_READY] = ready;
        rdata_mux[STAT_BUSY]  = busy;
      end
      default: rdata_mux = '0;
    endcase
  end

  // Read address and data channels
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      s_axi_arready <= 1'b0;
      s_axi_rvalid  <= 1'b0;
    end else begin
      s_axi_arready <= ~s_axi_arready & s_axi_arvalid;
      if (ar_hs) begin
        s_axi_rvalid <= 1'b1;
      end else if (s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (ar_hs) begin
      s_axi_rdata <= rdata_mux;
    end
  end

endmodule

`default_nettype wire

/* source/can_crc15.sv */
// Serial CAN CRC-15 engine, one bit per valid cycle
`timescale 1ns/1ns
`default_nettype none

module can_crc15 (
  input  wire                     s_axi_aclk,
  input  wire                     s_axi_aresetn,
  input  wire                     crc_clear,
  input  wire                     crc_bit_valid,
  input  wire                     crc_bit,
  output can_frame_pkg::can_crc_t crc
);

  import can_frame_pkg::*;

  logic     feedback;
  can_crc_t shifted;
  can_crc_t crc_next;

  assign feedback = crc_bit ^ crc[CAN_CRC_W-1];
  assign shifted  = {crc[CAN_CRC_W-2:0], 1'b0};
  assign crc_next = feedback ? (shifted ^ CAN_CRC_POLY) : shifted;

  // Clear wins over a bit in the same cycle
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      crc <= '0;
    end else if (crc_clear) begin
      crc <= '0;
    end else if (crc_bit_valid) begin
      crc <= crc_next;
    end
  end

endmodule

`default_nettype wire

/* source/can_frame_builder.sv */
// Frame builder that feeds the CRC engine bit by bit and holds the finished frame word
`timescale 1ns/1ns
`default_nettype none

module can_frame_builder (
  input  wire                       s_axi_aclk,
  input  wire                       s_axi_aresetn,
  input  wire can_frame_pkg::can_id_t   id,
  input  wire can_frame_pkg::can_dlc_t  dlc,
  input  wire                       rtr,
  input  wire                       ide,
  input  wire can_frame_pkg::can_data_t data,
  input  wire                       start,
  input  wire can_frame_pkg::can_crc_t  crc,
  output logic                      crc_clear,
  output logic                      crc_bit_valid,
  output logic                      crc_bit,
  output can_frame_pkg::can_frame_u frame,
  output logic                      frame_ready,
  output logic                      busy
);

  import can_frame_pkg::*;

  logic       accept;
  logic       feeding;
  logic       last_bit;
  logic [6:0] bit_cnt;
  logic [6:0] bit_total;
  logic [3:0] nbytes;
  can_data_t  data_mask;
  can_frame_u captured;
  can_frame_u work;
  can_frame_u finished;

  // Start while busy is dropped
  assign accept        = start & ~busy;
  assign crc_clear     = accept;
  assign crc_bit_valid = feeding;
  assign crc_bit       = work.raw[can_bit_index(bit_cnt)];
  assign last_bit      = feeding && (bit_cnt == bit_total - 7'd1);

  // Bytes carried, none for a remote frame
  always_comb begin
    nbytes = (dlc > 4'd8) ? 4'd8 : dlc;
    if (rtr) begin
      nbytes = 4'd0;
    end
    for (int i = 0; i < 8; i++) begin
      data_mask[CAN_DATA_W-1-8*i -: 8] = (i < nbytes) ? 8'hff : 8'h00;
    end
  end

  always_comb begin
    captured.raw         = '0;
    captured.fields.data = data & data_mask;
    captured.fields.dlc  = dlc;
    captured.fields.ide  = ide;
    captured.fields.rtr  = rtr;
    captured.fields.id   = id;
  end

  always_comb begin
    finished            = work;
    finished.fields.crc = crc;
  end

  always_ff @(posedge s_axi_aclk) begin
    if (accept) begin
      work      <= captured;
      bit_total <= 7'(CAN_HDR_BITS) + {nbytes, 3'b000};
    end
  end

  // Capture, feed N bits, then one cycle to latch the CRC
  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
    if (!s_axi_aresetn) begin
      busy        <= 1'b0;
      feeding     <= 1'b0;
      bit_cnt     <= '0;
      frame_ready <= 1'b0;
      frame       <= '0;
    end else if (accept) begin
      busy        <= 1'b1;
      feeding     <= 1'b1;
      bit_cnt     <= '0;
      frame_ready <= 1'b0;
    end else if (feeding) begin
      bit_cnt <= bit_cnt + 7'd1;
      if (last_bit) begin
        feeding <= 1'b0;
      end
    end else if (busy) begin
      frame       <= finished;
      frame_ready <= 1'b1;
      busy        <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* source/can_frame_assembler.sv */
// Top level joining the AXI4-Lite register block, CRC-15 engine and frame builder
`timescale 1ns/1ns
`default_nettype none

module can_frame_assembler #(
  parameter int AXI_ADDR_WIDTH = 32
) (
  input  wire                      s_axi_aclk,
  input  wire                      s_axi_aresetn,
  input  wire [AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
  input  wire [2:0]                s_axi_awprot,
  input  wire                      s_axi_awvalid,
  output logic                     s_axi_awready,
  input  wire [31:0]               s_axi_wdata,
  input  wire [3:0]                s_axi_wstrb,
  input  wire                      s_axi_wvalid,
  output logic                     s_axi_wready,
  output logic [1:0]               s_axi_bresp,
  output logic                     s_axi_bvalid,
  input  wire                      s_axi_bready,
  input  wire [AXI_ADDR_WIDTH-1:0] s_axi_araddr,
  input  wire [2:0]                s_axi_arprot,
  input  wire                      s_axi_arvalid,
  output logic                     s_axi_arready,
  output logic [31:0]              s_axi_rdata,
  output logic [1:0]               s_axi_rresp,
  output logic                     s_axi_rvalid,
  input  wire                      s_axi_rready,
  output logic [can_frame_pkg::CAN_FRAME_W-1:0] frame,
  output logic                     frame_ready
);

  import can_frame_pkg::*;

  can_id_t    id;
  can_dlc_t   dlc;
  logic       rtr;
  logic       ide;
  can_data_t  data;
  logic       start;
  logic       busy;
  logic       crc_clear;
  logic       crc_bit_valid;
  logic       crc_bit;
  can_crc_t   crc;
  can_frame_u frame_u;

  assign frame = frame_u.raw;

  can_axil_regs #(
    .AXI_ADDR_WIDTH (AXI_ADDR_WIDTH)
  ) u_regs (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awprot  (s_axi_awprot),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arprot  (s_axi_arprot),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .ready         (frame_ready),
    .busy          (busy),
    .id            (id),
    .dlc           (dlc),
    .rtr           (rtr),
    .ide           (ide),
    .data          (data),
    .start         (start)
  );

  can_crc15 u_crc (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .crc_clear     (crc_clear),
    .crc_bit_valid (crc_bit_valid),
    .crc_bit       (crc_bit),
    .crc           (crc)
  );

  can_frame_builder u_builder (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .id            (id),
    .dlc           (dlc),
    .rtr           (rtr),
    .ide           (ide),
    .data          (data),
    .start         (start),
    .crc           (crc),
    .crc_clear     (crc_clear),
    .crc_bit_valid (crc_bit_valid),
    .crc_bit       (crc_bit),
    .frame         (frame_u),
    .frame_ready   (frame_ready),
    .busy          (busy)
  );

endmodule

`default_nettype wire

/* sim/can_frame_assembler_sva.sv */
// Bound assertions on AXI response hold, ignored starts and frame_ready falls
`timescale 1ns/1ns
`default_nettype none

module can_frame_assembler_sva (
  input wire       s_axi_aclk,
  input wire       s_axi_aresetn,
  input wire       s_axi_bvalid,
  input wire       s_axi_bready,
  input wire       s_axi_rvalid,
  input wire       s_axi_rready,
  input wire       start,
  input wire       busy,
  input wire       crc_bit_valid,
  input wire [6:0] bit_cnt,
  input wire       frame_ready
);

  int fail_cnt = 0;

  a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else begin
      fail_cnt++;
      $error("bvalid fell before bready");
    end

  a_rvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
    else begin
      fail_cnt++;
      $error("rvalid fell before rready");
    end

  // A start during the bit feed must not restart it
  a_start_busy: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    start && busy && crc_bit_valid |=> bit_cnt == $past(bit_cnt) + 7'd1)
    else begin
      fail_cnt++;
      $error("start accepted while busy");
    end

  a_ready_fall: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    $fell(frame_ready) |-> $past(start && !busy))
    else begin
      fail_cnt++;
      $error("frame_ready fell without an accepted start");
    end

endmodule

bind can_frame_assembler can_frame_assembler_sva u_sva (
  .s_axi_aclk    (s_axi_aclk),
  .s_axi_aresetn (s_axi_aresetn),
  .s_axi_bvalid  (s_axi_bvalid),
  .s_axi_bready  (s_axi_bready),
  .s_axi_rvalid  (s_axi_rvalid),
  .s_axi_rready  (s_axi_rready),
  .start         (start),
  .busy          (busy),
  .crc_bit_valid (crc_bit_valid),
  .bit_cnt       (u_builder.bit_cnt),
  .frame_ready   (frame_ready)
);

`default_nettype wire

/* sim/tb_can_frame_assembler.sv */
// Testbench for the CAN frame assembler with AXI tasks, file vectors, compare tasks and watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_can_frame_assembler;

  import can_frame_pkg::*;
  import can_regmap_pkg::*;

  localparam int NUM_VEC  = 4;
  localparam int WATCHDOG = NUM_VEC * 200 + 2000;

  logic         s_axi_aclk;
  logic         s_axi_aresetn;
  logic [31:0]  s_axi_awaddr;
  logic [2:0]   s_axi_awprot;
  logic         s_axi_awvalid;
  logic         s_axi_awready;
  logic [31:0]  s_axi_wdata;
  logic [3:0]   s_axi_wstrb;
  logic         s_axi_wvalid;
  logic         s_axi_wready;
  logic [1:0]   s_axi_bresp;
  logic         s_axi_bvalid;
  logic         s_axi_bready;
  logic [31:0]  s_axi_araddr;
  logic [2:0]   s_axi_arprot;
  logic         s_axi_arvalid;
  logic         s_axi_arready;
  logic [31:0]  s_axi_rdata;
  logic [1:0]   s_axi_rresp;
  logic         s_axi_rvalid;
  logic         s_axi_rready;
  logic [127:0] frame;
  logic         frame_ready;

  // Seven words per vector: id, dlc, rtr, ide, data, crc, frame
  logic [127:0] vec_mem [0:NUM_VEC*7-1];
  int           word_errs;
  int           frame_errs;
  int           resp_errs;
  int           other_errs;
  int           assert_errs;
  integer       seed;

  can_frame_assembler #(
    .AXI_ADDR_WIDTH (32)
  ) u_can_frame_assembler (.*);

  initial begin
    s_axi_aclk = 1'b0;
    forever #10 s_axi_aclk = ~s_axi_aclk;
  end

  initial begin
    repeat (WATCHDOG) @(posedge s_axi_aclk);
    $display("Run timed out after %0d cycles without finishing the tests", WATCHDOG);
    $display("RESULT: FAIL");
    $finish;
  end

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      word_errs++;
      $display("Error at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_frame(input string what, input can_frame_u got, input can_frame_u exp);
    if (got.raw !== exp.raw) begin
      frame_errs++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got.raw, exp.raw);
    end
  endtask

  task automatic check_resp(input string what, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      resp_errs++;
      $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Expected frame and CRC straight from the frame layout and the CRC-15 rule
  function automatic can_frame_u build_frame(input logic [10:0] id, input logic [3:0] dlc,
                                             input logic rtr, input logic ide,
                                             input logic [63:0] data);
    can_frame_u  f;
    logic [82:0] seq;
    logic [14:0] c;
    logic        fb;
    int          nbytes;
    nbytes = rtr ? 0 : ((dlc > 4'd8) ? 8 : int'(dlc));
    f.raw = '0;
    for (int i = 0; i < nbytes; i++) begin
      f.fields.data[63-8*i -: 8] = data[63-8*i -: 8];
    end
    f.fields.dlc = dlc;
    f.fields.ide = ide;
    f.fields.rtr = rtr;
    f.fields.id  = id;
    // Wire order, first bit on the left
    seq = {1'b0, id, rtr, ide, 1'b0, dlc, f.fields.data};
    c = '0;
    for (int i = 0; i < 19 + 8 * nbytes; i++) begin
      fb = seq[82-i] ^ c[14];
      c = {c[13:0], 1'b0};
      if (fb) begin
        c = c ^ 15'h4599;
      end
    end
    f.fields.crc = c;
    return f;
  endfunction

  function automatic logic [31:0] control_word(input logic [3:0] dlc, input logic rtr,
                                               input logic ide);
    return (32'(ide) << CTRL_IDE) | (32'(rtr) << CTRL_RTR) | 32'(dlc);
  endfunction

  task automatic axi_write(input logic [3:0] off, input logic [31:0] val);
    logic seen;
    int   hold;
    s_axi_awaddr  = 32'(off) << 2;
    s_axi_awvalid = 1'b1;
    s_axi_wdata   = val;
    s_axi_wstrb   = 4'hf;
    s_axi_wvalid  = 1'b1;
    do begin
      seen = s_axi_awready;
      @(posedge s_axi_aclk) #2;
    end while (!seen);
    s_axi_awvalid = 1'b0;
    do begin
      seen = s_axi_wready;
      @(posedge s_axi_aclk) #2;
    end while (!seen);
    s_axi_wvalid = 1'b0;
    hold = $unsigned($random(seed)) % 4;
    repeat (hold) begin
      @(posedge s_axi_aclk) #2;
      if (!s_axi_bvalid) begin
        other_errs++;
        $display("bvalid went low at %0t while bready was still held low", $time);
      end
    end
    check_resp("bresp", s_axi_bresp, AXI_RESP_OKAY);
    s_axi_bready = 1'b1;
    do begin
      seen = s_axi_bvalid;
      @(posedge s_axi_aclk) #2;
    end while (!seen);
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] off, output logic [31:0] val);
    logic seen;
    int   hold;
    s_axi_araddr  = 32'(off) << 2;
    s_axi_arvalid = 1'b1;
    do begin
      seen = s_axi_arready;
      @(posedge s_axi_aclk) #2;
    end while (!seen);
    s_axi_arvalid = 1'b0;
    val = s_axi_rdata;
    check_resp("rresp", s_axi_rresp, AXI_RESP_OKAY);
    hold = $unsigned($random(seed)) % 4;
    repeat (hold) begin
      @(posedge s_axi_aclk) #2;
      if (!s_axi_rvalid) begin
        other_errs++;
        $display("rvalid went low at %0t while rready was still held low", $time);
      end
      check_word("held rdata", s_axi_rdata, val);
    end
    s_axi_rready = 1'b1;
    do begin
      seen = s_axi_rvalid;
      @(posedge s_axi_aclk) #2;
    end while (!seen);
    s_axi_rready = 1'b0;
  endtask

  task automatic readback_regs(input logic [10:0] id, input logic [63:0] data,
                               input logic [31:0] ctrl);
    logic [31:0] rd;
    axi_read(REG_ID, rd);
    check_word("ID register", rd, 32'(id));
    for (int i = 0; i < 8; i++) begin
      axi_read(4'(REG_DATA0 + i), rd);
      check_word("DATA register", rd, 32'(data[63-8*i -: 8]));
    end
    axi_read(REG_CONTROL, rd);
    check_word("CONTROL register", rd, ctrl);
  endtask

  task automatic run_vector(input int v, input bit restart);
    logic [10:0] id;
    logic [3:0]  dlc;
    logic        rtr;
    logic        ide;
    logic [63:0] data;
    logic [31:0] ctrl;
    logic [31:0] rd;
    can_frame_u  exp_f;
    can_frame_u  file_f;
    can_frame_u  got_f;
    id         = vec_mem[v*7][10:0];
    dlc        = vec_mem[v*7+1][3:0];
    rtr        = vec_mem[v*7+2][0];
    ide        = vec_mem[v*7+3][0];
    data       = vec_mem[v*7+4][63:0];
    file_f.raw = vec_mem[v*7+6];
    exp_f = build_frame(id, dlc, rtr, ide, data);
    check_frame("rebuilt frame against file", exp_f, file_f);
    if (exp_f.fields.crc !== vec_mem[v*7+5][14:0]) begin
      other_errs++;
      $display("Computed CRC %h does not match the file CRC of vector %0d", exp_f.fields.crc, v);
    end
    ctrl = control_word(dlc, rtr, ide);
    axi_write(REG_ID, 32'(id));
    for (int i = 0; i < 8; i++) begin
      axi_write(4'(REG_DATA0 + i), 32'(data[63-8*i -: 8]));
    end
    axi_write(REG_CONTROL, ctrl);
    readback_regs(id, data, ctrl);
    axi_write(REG_CONTROL, ctrl | (32'd1 << CTRL_ASSEMBLE));
    axi_read(REG_STATUS, rd);
    check_word("status after start", rd, 32'h2);
    if (restart) begin
      // Flipped rtr, so an accepted restart would build a different frame
      ctrl = ctrl ^ (32'd1 << CTRL_RTR);
      axi_write(REG_CONTROL, ctrl | (32'd1 << CTRL_ASSEMBLE));
    end
    do begin
      axi_read(REG_STATUS, rd);
    end while (!rd[STAT_READY]);
    check_word("status when done", rd, 32'h1);
    if (!frame_ready) begin
      other_errs++;
      $display("frame_ready is low although the status register reports ready");
    end
    got_f.raw = frame;
    check_frame("assembled frame", got_f, file_f);
    axi_read(REG_CONTROL, rd);
    check_word("CONTROL after assemble", rd, ctrl);
  endtask

  initial begin
    logic [31:0] rd;
    int          last;
    seed          = 32'h676c;
    word_errs     = 0;
    frame_errs    = 0;
    resp_errs     = 0;
    other_errs    = 0;
    assert_errs   = 0;
    s_axi_aresetn = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awprot  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arprot  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    $readmemh("sim/can_frame_input.txt", vec_mem);
    repeat (16) @(posedge s_axi_aclk);
    #2 s_axi_aresetn = 1'b1;
    @(posedge s_axi_aclk) #2;
    // First vector also gets a second assemble while busy
    run_vector(0, 1'b1);
    for (int v = 1; v < NUM_VEC; v++) begin
      run_vector(v, 1'b0);
    end
    for (int off = 11; off < 16; off++) begin
      axi_read(4'(off), rd);
      check_word("unmapped offset", rd, 32'h0);
      axi_write(4'(off), 32'h7ff);
    end
    // Unmapped writes leave the last vector's registers in place
    last = NUM_VEC - 1;
    readback_regs(vec_mem[last*7][10:0], vec_mem[last*7+4][63:0],
                  control_word(vec_mem[last*7+1][3:0], vec_mem[last*7+2][0],
                               vec_mem[last*7+3][0]));
    assert_errs = u_can_frame_assembler.u_sva.fail_cnt;
    $display("Errors: word %0d, frame %0d, resp %0d, other %0d, assertion %0d",
             word_errs, frame_errs, resp_errs, other_errs, assert_errs);
    if (word_errs + frame_errs + resp_errs + other_errs + assert_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/can_frame_input.txt */
// Columns in hex: id dlc rtr ide data crc frame, one vector per line
// Vector 0 data frame, 1 remote frame, 2 remote with dlc 9, 3 data frame with dlc 2
001 1 0 0 8000000000000000 5E3F 00000002F1FC00000000000000008002
400 0 1 0 FFFFFFFFFFFFFFFF 5674 00000002B3A000000000000000001800
000 9 1 1 0123456789ABCDEF 1975 00000000CBA80000000000000004B000
002 2 0 0 0180FF0000000000 5D7C 00000002EBE00C000000000000010004

/* sources.f */
source/can_frame_pkg.sv
source/can_regmap_pkg.sv
source/can_axil_regs.sv
source/can_crc15.sv
source/can_frame_builder.sv
source/can_frame_assembler.sv
sim/can_frame_assembler_sva.sv
sim/tb_can_frame_assembler.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile with Verilator, run the testbench and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_can_frame_assembler -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0
